// File: Makefile
# Verilator build and run of the TCM testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tcm_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/tcm_params.svh
// ------------------------------------------------
// TCM size and width macros, shared by RTL and testbench
// TCM_SIZE must be a power of two, at least 8 bytes
// TCM_DWIDTH stays 32, the byte lane logic assumes 4 lanes
// ------------------------------------------------
`ifndef TCM_PARAMS_SVH
`define TCM_PARAMS_SVH

// Core byte address width
`define TCM_AWIDTH 32

// Data word width
`define TCM_DWIDTH 32

// Memory size in bytes
`define TCM_SIZE 4096

// Word address width
`define TCM_WADDR_W ($clog2(`TCM_SIZE) - 2)

`endif

// File: project.f
+incdir+include
source/mem_if_pkg.sv
source/tcm_pkg.sv
source/tcm_wr_format.sv
source/tcm_dp_ram.sv
source/tcm_resp_unit.sv
source/tcm_top.sv
tests/tcm_tb.sv

// File: source/mem_if_pkg.sv
// ------------------------------------------------
// Core memory interface types
// Encodings follow the core's request/response rule
// ------------------------------------------------
`default_nettype none

`include "tcm_params.svh"

package mem_if_pkg;

    // --------------------------------------------------
    // Request command
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Data access width, 2'b11 unused
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response code, one cycle after the request
    typedef enum logic {
        MEM_RESP_NOTRDY = 1'b0,
        MEM_RESP_RDY_OK = 1'b1
    } mem_resp_e;

    // --------------------------------------------------
    // Data port request, valid while dmem_req is high
    typedef struct packed {
        mem_cmd_e                 cmd;
        mem_width_e               width;
        logic [`TCM_AWIDTH-1:0]   addr;
        logic [`TCM_DWIDTH-1:0]   wdata;
    } dmem_req_t;

endpackage : mem_if_pkg

`default_nettype wire

// File: source/tcm_dp_ram.sv
// ------------------------------------------------
// Dual-port RAM, port A read only, port B read/write
// Read-first on a same-word collision, no content reset
// ------------------------------------------------
`default_nettype none

`include "tcm_params.svh"

module tcm_dp_ram (
    input  logic                     clk,
    // Port A, instruction side
    input  logic [`TCM_WADDR_W-1:0]  raddr_a,
    output tcm_pkg::tcm_word_t       rdata_a,
    // Port B, data side
    input  logic [`TCM_WADDR_W-1:0]  raddr_b,
    input  tcm_pkg::tcm_wr_t         wr,
    output tcm_pkg::tcm_word_t       rdata_b
);

    import tcm_pkg::*;

    // Words in the array
    localparam int DEPTH = `TCM_SIZE / 4;
    // Byte lanes per word
    localparam int LANES = `TCM_DWIDTH / 8;

    // --------------------------------------------------
    // Storage, each word split into byte lanes
    logic [LANES-1:0][7:0] mem [0:DEPTH-1];

    // Port A read register
    // Reads every cycle, the response unit decides validity
    always_ff @(posedge clk) begin
        rdata_a <= tcm_word_t'(mem[raddr_a]);
    end

    // --------------------------------------------------
    // Port B, read and byte write at the same edge
    // Nonblocking update keeps the old word on the read
    always_ff @(posedge clk) begin
        rdata_b <= tcm_word_t'(mem[raddr_b]);
        if (wr.wen) begin
            for (int i = 0; i < LANES; i++) begin
                // Only the enabled lanes change
                if (wr.byteen[i]) begin
                    mem[wr.waddr][i] <= wr.data[i*8 +: 8];
                end
            end
        end
    end

endmodule : tcm_dp_ram

`default_nettype wire

// File: source/tcm_pkg.sv
// ------------------------------------------------
// RAM side types of the TCM
// ------------------------------------------------
`default_nettype none

`include "tcm_params.svh"

package tcm_pkg;

    // --------------------------------------------------
    // One RAM word
    typedef logic [`TCM_DWIDTH-1:0] tcm_word_t;

    // Formatted port B write
    // Data already replicated into the enabled lanes
    typedef struct packed {
        // Write strobe, request and write command
        logic                      wen;
        // One bit per byte lane
        logic [3:0]                byteen;
        // Word address, upper address bits dropped
        logic [`TCM_WADDR_W-1:0]   waddr;
        tcm_word_t                 data;
    } tcm_wr_t;

endpackage : tcm_pkg

`default_nettype wire

// File: source/tcm_resp_unit.sv
// ------------------------------------------------
// Response codes and read data alignment
// Sub-word data comes back zero filled, not extended
// ------------------------------------------------
`default_nettype none

module tcm_resp_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    // Request strobes of both ports
    input  logic                    imem_req,
    input  logic                    dmem_req,
    // Byte offset of the data request
    input  logic [1:0]              dmem_offset,
    // Registered RAM words
    input  tcm_pkg::tcm_word_t      ram_rdata_a,
    input  tcm_pkg::tcm_word_t      ram_rdata_b,
    // Core side
    output tcm_pkg::tcm_word_t      imem_rdata,
    output mem_if_pkg::mem_resp_e   imem_resp,
    output tcm_pkg::tcm_word_t      dmem_rdata,
    output mem_if_pkg::mem_resp_e   dmem_resp
);

    import mem_if_pkg::*;

    // --------------------------------------------------
    // Offset of the data access now being answered
    logic [1:0] offset_q;

    // --------------------------------------------------
    // Response codes
    // Every request is accepted, so the code just follows req
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_resp <= MEM_RESP_NOTRDY;
            dmem_resp <= MEM_RESP_NOTRDY;
        end else begin
            imem_resp <= imem_req ? MEM_RESP_RDY_OK : MEM_RESP_NOTRDY;
            dmem_resp <= dmem_req ? MEM_RESP_RDY_OK : MEM_RESP_NOTRDY;
        end
    end

    // Offset capture, same cycle as the RAM read
    // Held through idle cycles, data is undefined there anyway
    always_ff @(posedge clk) begin
        if (dmem_req) begin
            offset_q <= dmem_offset;
        end
    end

    // --------------------------------------------------
    // Read data
    // Instruction fetch is always a whole word
    assign imem_rdata = ram_rdata_a;

    // Addressed byte moved down to bit 0, zeros above
    assign dmem_rdata = ram_rdata_b >> {offset_q, 3'b000};

endmodule : tcm_resp_unit

`default_nettype wire

// File: source/tcm_top.sv
// ------------------------------------------------
// TCM top, instruction and data port on one RAM
// One cycle latency, no back-pressure, no error codes
// Address bits above the memory size are ignored
// ------------------------------------------------
`default_nettype none

`include "tcm_params.svh"

module tcm_top (
    input  logic                     clk,
    input  logic                     rst_n,

    // Instruction port, word reads only
    input  logic                     imem_req,
    input  logic [`TCM_AWIDTH-1:0]   imem_addr,
    output tcm_pkg::tcm_word_t       imem_rdata,
    output mem_if_pkg::mem_resp_e    imem_resp,

    // Data port
    input  logic                     dmem_req,
    input  mem_if_pkg::dmem_req_t    dmem,
    output tcm_pkg::tcm_word_t       dmem_rdata,
    output mem_if_pkg::mem_resp_e    dmem_resp
);

    import tcm_pkg::*;

    // --------------------------------------------------
    // Internal nets
    // Formatted data write
    tcm_wr_t                   wr;
    // Word addresses for the RAM reads
    logic [`TCM_WADDR_W-1:0]   imem_waddr;
    logic [`TCM_WADDR_W-1:0]   dmem_waddr;
    // Registered RAM words
    tcm_word_t                 ram_rdata_a;
    tcm_word_t                 ram_rdata_b;

    // Word address slices, wrap at the memory size
    assign imem_waddr = imem_addr[`TCM_WADDR_W+1:2];
    assign dmem_waddr = dmem.addr[`TCM_WADDR_W+1:2];

    // --------------------------------------------------
    // Input side
    tcm_wr_format u_wr_format (
        .dmem_req  (dmem_req),
        .dmem      (dmem),
        .wr        (wr)
    );

    // RAM, port A fetch and port B data
    tcm_dp_ram u_ram (
        .clk       (clk),
        .raddr_a   (imem_waddr),
        .rdata_a   (ram_rdata_a),
        .raddr_b   (dmem_waddr),
        .wr        (wr),
        .rdata_b   (ram_rdata_b)
    );

    // --------------------------------------------------
    // Output side
    tcm_resp_unit u_resp (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .dmem_req     (dmem_req),
        .dmem_offset  (dmem.addr[1:0]),
        .ram_rdata_a  (ram_rdata_a),
        .ram_rdata_b  (ram_rdata_b),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp)
    );

endmodule : tcm_top

`default_nettype wire

// File: source/tcm_wr_format.sv
// ------------------------------------------------
// Data port write formatting, purely combinational
// Sub-word alignment checks are left to the core
// ------------------------------------------------
`default_nettype none

`include "tcm_params.svh"

module tcm_wr_format (
    input  logic                   dmem_req,
    input  mem_if_pkg::dmem_req_t  dmem,
    output tcm_pkg::tcm_wr_t       wr
);

    import mem_if_pkg::*;
    import tcm_pkg::*;

    // Byte lanes per word
    localparam int LANES = `TCM_DWIDTH / 8;

    // --------------------------------------------------
    // Lane data and enables
    tcm_word_t   wdata_rep;
    logic [3:0]  byteen;

    always_comb begin
        // Word access by default
        wdata_rep = dmem.wdata;
        byteen    = 4'b1111;
        case (dmem.width)
            MEM_WIDTH_BYTE: begin
                // Low byte into every lane
                wdata_rep = {LANES{dmem.wdata[7:0]}};
                byteen    = 4'b0001 << dmem.addr[1:0];
            end
            MEM_WIDTH_HWORD: begin
                // Low halfword twice, bit 0 of address ignored
                wdata_rep = {(LANES / 2){dmem.wdata[15:0]}};
                byteen    = 4'b0011 << {dmem.addr[1], 1'b0};
            end
            default: begin
                // Word, bits 1:0 ignored
            end
        endcase
    end

    // --------------------------------------------------
    // Write record for RAM port B
    always_comb begin
        wr.wen    = dmem_req & (dmem.cmd == MEM_CMD_WR);
        wr.byteen = byteen;
        // Address wraps at the memory size
        wr.waddr  = dmem.addr[`TCM_WADDR_W+1:2];
        wr.data   = wdata_rep;
    end

endmodule : tcm_wr_format

`default_nettype wire

// File: tests/tcm_tb.sv
// ------------------------------------------------
// Random traffic on both TCM ports
// Byte array model with zero filled data reads
// ------------------------------------------------
`default_nettype none

`include "tcm_params.svh"

module tcm_tb;

    import mem_if_pkg::*;
    import tcm_pkg::*;

    // Test length and clock
    localparam int DEPTH        = `TCM_SIZE / 4;
    localparam int BYTE_AW      = $clog2(`TCM_SIZE);
    localparam int N_RANDOM     = 2000;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    // --------------------------------------------------
    // Expected response for one request cycle
    typedef struct packed {
        mem_resp_e  iresp;
        logic       icheck;
        tcm_word_t  iword;
        mem_resp_e  dresp;
        logic       dcheck;
        tcm_word_t  dword;
    } expect_t;

    // DUT signals
    logic                    clk;
    logic                    rst_n;
    logic                    imem_req;
    logic [`TCM_AWIDTH-1:0]  imem_addr;
    tcm_word_t               imem_rdata;
    mem_resp_e               imem_resp;
    logic                    dmem_req;
    dmem_req_t               dmem;
    tcm_word_t               dmem_rdata;
    mem_resp_e               dmem_resp;

    integer     seed;
    int         resp_errors;
    int         word_errors;
    // Reference memory with one entry per byte
    logic [7:0] model_mem [0:`TCM_SIZE-1];
    expect_t    exp_q [$];

    tcm_top u_tcm_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .imem_resp   (imem_resp),
        .dmem_req    (dmem_req),
        .dmem        (dmem),
        .dmem_rdata  (dmem_rdata),
        .dmem_resp   (dmem_resp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // Compare tasks
    task automatic check_resp(input string name, input mem_resp_e got, input mem_resp_e exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %s expected %s",
                     $time, name, got.name(), exp.name());
            resp_errors++;
        end
    endtask

    task automatic check_word(input string name, input tcm_word_t got, input tcm_word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    // --------------------------------------------------
    // Model access drops the upper address bits
    function automatic tcm_word_t read_model_word(input logic [`TCM_AWIDTH-1:0] addr);
        logic [BYTE_AW-3:0] w;
        w = addr[BYTE_AW-1:2];
        return {model_mem[{w, 2'd3}], model_mem[{w, 2'd2}],
                model_mem[{w, 2'd1}], model_mem[{w, 2'd0}]};
    endfunction

    task automatic apply_write(input dmem_req_t d);
        logic [BYTE_AW-3:0] w;
        w = d.addr[BYTE_AW-1:2];
        case (d.width)
            MEM_WIDTH_BYTE: begin
                model_mem[d.addr[BYTE_AW-1:0]] = d.wdata[7:0];
            end
            MEM_WIDTH_HWORD: begin
                // Bit 0 of the address plays no part
                model_mem[{d.addr[BYTE_AW-1:1], 1'b0}] = d.wdata[7:0];
                model_mem[{d.addr[BYTE_AW-1:1], 1'b1}] = d.wdata[15:8];
            end
            default: begin
                model_mem[{w, 2'd0}] = d.wdata[7:0];
                model_mem[{w, 2'd1}] = d.wdata[15:8];
                model_mem[{w, 2'd2}] = d.wdata[23:16];
                model_mem[{w, 2'd3}] = d.wdata[31:24];
            end
        endcase
    endtask

    // --------------------------------------------------
    // Drive one cycle at the falling edge and queue its answer
    task automatic issue_cycle(input logic ireq, input logic [`TCM_AWIDTH-1:0] iaddr,
                               input logic dreq, input dmem_req_t d);
        expect_t e;
        imem_req  = ireq;
        imem_addr = iaddr;
        dmem_req  = dreq;
        dmem      = d;
        e.iresp   = ireq ? MEM_RESP_RDY_OK : MEM_RESP_NOTRDY;
        e.icheck  = ireq;
        e.iword   = read_model_word(iaddr);
        e.dresp   = dreq ? MEM_RESP_RDY_OK : MEM_RESP_NOTRDY;
        e.dcheck  = dreq && (d.cmd == MEM_CMD_RD);
        // Addressed byte moves down to bit 0 with zeros on top
        e.dword   = read_model_word(d.addr) >> (8 * int'(d.addr[1:0]));
        exp_q.push_back(e);
        // Read-first means the write lands after the reads above
        if (dreq && (d.cmd == MEM_CMD_WR)) begin
            apply_write(d);
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic compare_outputs();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("no expected response was queued at time %0t", $time);
            resp_errors++;
        end else begin
            e = exp_q.pop_front();
            check_resp("imem_resp", imem_resp, e.iresp);
            check_resp("dmem_resp", dmem_resp, e.dresp);
            if (e.icheck) begin
                check_word("imem_rdata", imem_rdata, e.iword);
            end
            if (e.dcheck) begin
                check_word("dmem_rdata", dmem_rdata, e.dword);
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    initial begin
        dmem_req_t               d;
        logic                    ireq;
        logic                    dreq;
        logic [`TCM_AWIDTH-1:0]  iaddr;
        logic [1:0]              wsel;
        seed        = 32'h94c8;
        resp_errors = 0;
        word_errors = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        imem_req    = 1'b0;
        imem_addr   = '0;
        dmem_req    = 1'b0;
        dmem        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_resp("imem_resp", imem_resp, MEM_RESP_NOTRDY);
        check_resp("dmem_resp", dmem_resp, MEM_RESP_NOTRDY);

        // Fill every word through the data port
        for (int w = 0; w < DEPTH; w++) begin
            d.cmd   = MEM_CMD_WR;
            d.width = MEM_WIDTH_WORD;
            d.addr  = w * 4;
            d.wdata = $random(seed);
            issue_cycle(1'b0, '0, 1'b1, d);
            @(negedge clk);
            compare_outputs();
        end

        // Mixed traffic with each port busy about 3 cycles in 4
        for (int n = 0; n < N_RANDOM; n++) begin
            ireq    = ($random(seed) & 3) != 0;
            dreq    = ($random(seed) & 3) != 0;
            d.cmd   = (($random(seed) & 1) != 0) ? MEM_CMD_WR : MEM_CMD_RD;
            wsel    = 2'({$random(seed)} % 3);
            d.width = mem_width_e'(wsel);
            d.wdata = $random(seed);
            d.addr  = $random(seed);
            // High address bits kept now and then
            if (($random(seed) & 3) != 0) begin
                d.addr = d.addr & (`TCM_SIZE - 1);
            end
            // Same word on both ports for read-first
            if (($random(seed) & 3) == 0) begin
                iaddr = d.addr;
            end else begin
                iaddr = $random(seed);
            end
            issue_cycle(ireq, iaddr, dreq, d);
            @(negedge clk);
            compare_outputs();
        end

        // Idle cycle brings both codes back to not-ready
        issue_cycle(1'b0, '0, 1'b0, d);
        @(negedge clk);
        compare_outputs();

        $display("resp errors: %0d, word errors: %0d", resp_errors, word_errors);
        if ((resp_errors == 0) && (word_errors == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // --------------------------------------------------
    // Watchdog covers fill plus random cycles plus margin
    initial begin
        #((DEPTH + N_RANDOM + 20) * CLK_PERIOD);
        $display("simulation timed out before the test sequence finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule : tcm_tb

`default_nettype wire
